/* compile.f */
+incdir+include
src/mem_addr_pkg.sv
src/cache_pkg.sv
src/line_store.sv
src/write_queue.sv
src/backend_stage.sv
src/cache_stage.sv
src/data_mem_top.sv
bench/tb_data_mem.sv

/* run.sh */
#!/usr/bin/env bash
# Build the data memory testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module tb_data_mem -o tb_data_mem \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/tb_data_mem | tee /dev/stderr | grep -qx "STATUS: PASS" \
    && exit 0 || exit 1

/* bench/tb_data_mem.sv */
`timescale 1ns/1ps
`include "mem_params.svh"

module tb_data_mem;

    import mem_addr_pkg::*;

    localparam int TIMEOUT = 100;   // Cycles per wait
    localparam int WORDS   = 1 << `ADDR_W;

    logic       clk;
    logic       rst;
    logic       req_valid;
    logic       req_write;
    word_addr_t req_addr;
    word_t      req_wdata;
    logic       req_ready;
    logic       resp_valid;
    word_t      resp_rdata;

    word_t      shadow [WORDS];     // Last value written per word
    word_t      exp_data_q [$];
    word_addr_t exp_addr_q [$];

    integer seed;
    int     cycle;
    int     accept_cycle;
    int     last_resp_cycle;
    int     error_count;
    int     test_errors;
    int     tests_run;
    int     tests_failed;
    string  test_name;

    data_mem_top i_dut (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_write  (req_write),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp_rdata (resp_rdata)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Expected read data is zero where nothing was written
    function automatic word_t expected_read(word_addr_t addr);
        return shadow[addr];
    endfunction

    // Four tags share each of four indexes and evict each other
    function automatic word_addr_t random_addr(int r);
        return {r[5:4], 6'b000000, r[3:0]};
    endfunction

    task automatic count_error();
        error_count++;
        test_errors++;
    endtask

    task automatic abort_run(input string why);
        $display("%s in test %s", why, test_name);
        $display("STATUS: FAIL");
        $finish;
    endtask

    // Responses are compared in acceptance order
    always @(negedge clk) begin
        word_t      exp_data;
        word_addr_t exp_addr;
        if (!rst && resp_valid) begin
            last_resp_cycle = cycle;
            assert (exp_data_q.size() > 0) else begin
                $display("A response arrived in %s with no read outstanding", test_name);
                count_error();
            end
            if (exp_data_q.size() > 0) begin
                exp_data = exp_data_q.pop_front();
                exp_addr = exp_addr_q.pop_front();
                assert (resp_rdata === exp_data) else begin
                    $display("FAILED %s: read of %03h expected %08h actual %08h",
                             test_name, exp_addr, exp_data, resp_rdata);
                    count_error();
                end
            end
        end
    end

    task automatic wait_ready();
        int n;
        n = 0;
        while (!req_ready) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) begin
                abort_run("req_ready stayed low too long");
            end
        end
    endtask

    // Hold one request until it is taken and then release it
    task automatic do_request(input logic write, input word_addr_t addr, input word_t data);
        req_valid = 1'b1;
        req_write = write;
        req_addr  = addr;
        req_wdata = data;
        wait_ready();
        accept_cycle = cycle + 1;   // Taken at the coming edge
        if (write) begin
            shadow[addr] = data;
        end else begin
            exp_data_q.push_back(expected_read(addr));
            exp_addr_q.push_back(addr);
        end
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic wait_responses();
        int n;
        n = 0;
        while (exp_data_q.size() != 0) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) begin
                abort_run("A read got no response in time");
            end
        end
    endtask

    // Read that must hit and answer in the cycle after acceptance
    task automatic read_hit(input word_addr_t addr);
        do_request(1'b0, addr, '0);
        wait_responses();
        assert (last_resp_cycle == accept_cycle) else begin
            $display("Read of %03h in %s was not answered in the cycle after acceptance",
                     addr, test_name);
            count_error();
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        wait_responses();
        tests_run++;
        if (test_errors == 0) begin
            $display("Test %s passed", test_name);
        end else begin
            tests_failed++;
            $display("Test %s failed with %0d errors", test_name, test_errors);
        end
    endtask

    initial begin
        int         r;
        word_addr_t a;
        clk       = 1'b0;
        rst       = 1'b1;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        seed      = 92117;
        cycle     = 0;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int i = 0; i < WORDS; i++) begin
            shadow[i] = '0;
        end

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        start_test("reset_state");
        assert (resp_valid === 1'b0) else begin
            $display("resp_valid was high right after reset");
            count_error();
        end
        assert (req_ready === 1'b1) else begin
            $display("req_ready was low right after reset");
            count_error();
        end
        do_request(1'b0, 12'h0a5, '0);
        finish_test();

        start_test("write_then_read");
        do_request(1'b1, 12'h123, $random(seed));
        do_request(1'b0, 12'h123, '0);      // Fill must see the queued write
        finish_test();

        start_test("hit_write_through");
        read_hit(12'h121);                  // Same line as the last fill
        do_request(1'b1, 12'h122, $random(seed));
        read_hit(12'h122);
        read_hit(12'h123);
        finish_test();

        start_test("back_pressure");
        for (int i = 0; i < 12; i++) begin
            do_request(1'b1, word_addr_t'(12'h300 + i * 5), $random(seed));
        end
        for (int i = 0; i < 12; i++) begin
            do_request(1'b0, word_addr_t'(12'h300 + i * 5), '0);
        end
        finish_test();

        start_test("eviction");
        // Index 0 with tags 1 and 2
        do_request(1'b1, 12'h040, $random(seed));
        do_request(1'b1, 12'h080, $random(seed));
        do_request(1'b0, 12'h040, '0);
        do_request(1'b0, 12'h080, '0);
        do_request(1'b0, 12'h040, '0);
        do_request(1'b0, 12'h080, '0);
        finish_test();

        start_test("random_traffic");
        for (int i = 0; i < 300; i++) begin
            r = $random(seed);
            a = random_addr(r);
            if (r[8]) begin
                do_request(1'b1, a, $random(seed));
            end else begin
                do_request(1'b0, a, '0);
            end
        end
        finish_test();

        $display("Tests run: %0d, tests failed: %0d, checks failed: %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* src/data_mem_top.sv */
`timescale 1ns/1ps
`include "mem_params.svh"

module data_mem_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req_valid,
    input  logic                     req_write,
    input  mem_addr_pkg::word_addr_t req_addr,
    input  mem_addr_pkg::word_t      req_wdata,
    output logic                     req_ready,
    output logic                     resp_valid,
    output mem_addr_pkg::word_t      resp_rdata
);

    import mem_addr_pkg::*;

    // Packed write entry with address above data
    logic [`ADDR_W+`WORD_W-1:0] wq_entry;
    logic [`ADDR_W+`WORD_W-1:0] wq_head;

    logic wq_push;
    logic wq_pop;
    logic wq_full;
    logic wq_empty;

    logic       fill_req;
    line_addr_t fill_addr;
    logic       fill_valid;
    line_t      fill_line;

    cache_stage i_cache_stage (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_write  (req_write),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp_rdata (resp_rdata),
        .wq_push    (wq_push),
        .wq_entry   (wq_entry),
        .wq_full    (wq_full),
        .fill_req   (fill_req),
        .fill_addr  (fill_addr),
        .fill_valid (fill_valid),
        .fill_line  (fill_line)
    );

    write_queue i_write_queue (
        .clk      (clk),
        .rst      (rst),
        .wq_push  (wq_push),
        .wq_entry (wq_entry),
        .wq_pop   (wq_pop),
        .wq_head  (wq_head),
        .wq_full  (wq_full),
        .wq_empty (wq_empty)
    );

    backend_stage i_backend_stage (
        .clk        (clk),
        .rst        (rst),
        .wq_empty   (wq_empty),
        .wq_head    (wq_head),
        .wq_pop     (wq_pop),
        .fill_req   (fill_req),
        .fill_addr  (fill_addr),
        .fill_valid (fill_valid),
        .fill_line  (fill_line)
    );

endmodule

/* src/cache_stage.sv */
`timescale 1ns/1ps
`include "mem_params.svh"

module cache_stage (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req_valid,
    input  logic                     req_write,
    input  mem_addr_pkg::word_addr_t req_addr,
    input  mem_addr_pkg::word_t      req_wdata,
    output logic                     req_ready,
    output logic                     resp_valid,
    output mem_addr_pkg::word_t      resp_rdata,
    output logic                     wq_push,
    output cache_pkg::write_entry_t  wq_entry,
    input  logic                     wq_full,
    output logic                     fill_req,
    output mem_addr_pkg::line_addr_t fill_addr,
    input  logic                     fill_valid,
    input  mem_addr_pkg::line_t      fill_line
);

    import mem_addr_pkg::*;
    import cache_pkg::*;

    // Tag and data arrays
    tag_t  tag_q  [`CACHE_LINES];
    line_t line_q [`CACHE_LINES];
    logic [`CACHE_LINES-1:0] valid_q;

    logic       miss_pending;
    word_addr_t miss_addr;      // Read that missed is held until the fill

    logic    accept;
    logic    fill_done;
    index_t  req_index;
    tag_t    req_tag;
    offset_t req_offset;
    logic    req_hit;
    index_t  miss_index;

    assign req_index  = index_of(line_of(req_addr));
    assign req_tag    = tag_of(line_of(req_addr));
    assign req_offset = offset_of(req_addr);
    assign req_hit    = valid_q[req_index] && (tag_q[req_index] == req_tag);
    assign miss_index = index_of(line_of(miss_addr));

    // No new request while a miss is open or the queue is full
    assign req_ready = !miss_pending && !wq_full;
    assign accept    = req_valid && req_ready;
    assign fill_done = fill_valid && miss_pending;

    // Every write goes through to memory
    assign wq_push       = accept && req_write;
    assign wq_entry.addr = req_addr;
    assign wq_entry.data = req_wdata;

    assign fill_req  = miss_pending;
    assign fill_addr = line_of(miss_addr);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q      <= '0;
            miss_pending <= 1'b0;
            resp_valid   <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            if (fill_done) begin
                valid_q[miss_index] <= 1'b1;   // Old entry evicted
                miss_pending        <= 1'b0;
                resp_valid          <= 1'b1;
            end else if (accept && !req_write) begin
                if (req_hit) begin
                    resp_valid <= 1'b1;
                end else begin
                    miss_pending <= 1'b1;
                end
            end
        end
    end

    // Arrays, miss address and read data
    always_ff @(posedge clk) begin
        if (fill_done) begin
            tag_q[miss_index]  <= tag_of(fill_addr);
            line_q[miss_index] <= fill_line;
            resp_rdata         <= word_of(fill_line, offset_of(miss_addr));
        end else if (accept) begin
            if (req_write) begin
                // Keep a cached copy current but never allocate
                if (req_hit) begin
                    line_q[req_index][req_offset*`WORD_W +: `WORD_W] <= req_wdata;
                end
            end else begin
                miss_addr  <= req_addr;
                resp_rdata <= word_of(line_q[req_index], req_offset);
            end
        end
    end

endmodule

/* src/backend_stage.sv */
`timescale 1ns/1ps
`include "mem_params.svh"

module backend_stage (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     wq_empty,
    input  cache_pkg::write_entry_t  wq_head,
    output logic                     wq_pop,
    input  logic                     fill_req,
    input  mem_addr_pkg::line_addr_t fill_addr,
    output logic                     fill_valid,
    output mem_addr_pkg::line_t      fill_line
);

    import mem_addr_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        DRAIN,
        FILL_WAIT,
        FILL_DONE
    } state_t;

    // Counts down the cycles between read issue and fill
    localparam int CNT_W = $clog2(`MEM_LATENCY);

    state_t           state;
    state_t           state_next;
    logic [CNT_W-1:0] lat_cnt;
    logic             fill_start;

    logic       st_write;
    logic       st_read;
    line_addr_t st_addr;
    offset_t    st_offset;
    word_t      st_wdata;
    line_t      st_rdata;

    // A fill waits for an empty queue and thus sees every earlier write
    assign fill_start = (state == IDLE || state == DRAIN) && wq_empty && fill_req;

    // One queued write per cycle
    assign wq_pop   = (state == DRAIN) && !wq_empty;
    assign st_write = wq_pop;
    assign st_read  = fill_start;

    assign st_addr   = st_read ? fill_addr : line_of(wq_head.addr);
    assign st_offset = offset_of(wq_head.addr);
    assign st_wdata  = wq_head.data;

    assign fill_valid = (state == FILL_DONE);
    assign fill_line  = st_rdata;          // Held by the store until the next read

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (!wq_empty) begin
                    state_next = DRAIN;
                end else if (fill_start) begin
                    state_next = FILL_WAIT;
                end
            end
            DRAIN: begin
                if (fill_start) begin
                    state_next = FILL_WAIT;
                end else if (wq_empty) begin
                    state_next = IDLE;
                end
            end
            FILL_WAIT: begin
                if (lat_cnt == '0) begin
                    state_next = FILL_DONE;
                end
            end
            FILL_DONE: state_next = IDLE;   // fill_req drops at this edge
            default:   state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            lat_cnt <= '0;
        end else begin
            state <= state_next;
            if (fill_start) begin
                lat_cnt <= CNT_W'(`MEM_LATENCY - 2);
            end else if (state == FILL_WAIT && lat_cnt != '0) begin
                lat_cnt <= lat_cnt - 1'b1;
            end
        end
    end

    line_store i_line_store (
        .clk       (clk),
        .st_write  (st_write),
        .st_addr   (st_addr),
        .st_offset (st_offset),
        .st_wdata  (st_wdata),
        .st_read   (st_read),
        .st_rdata  (st_rdata)
    );

endmodule

/* src/write_queue.sv */
`timescale 1ns/1ps
`include "mem_params.svh"

module write_queue (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    wq_push,
    input  cache_pkg::write_entry_t wq_entry,
    input  logic                    wq_pop,
    output cache_pkg::write_entry_t wq_head,
    output logic                    wq_full,
    output logic                    wq_empty
);

    import cache_pkg::*;

    localparam int PTR_W = $clog2(`WQ_DEPTH);

    write_entry_t entries [`WQ_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic [PTR_W:0]   count_next;
    logic             do_push;
    logic             do_pop;

    assign do_push = wq_push && !wq_full;
    assign do_pop  = wq_pop && !wq_empty;

    always_comb begin
        count_next = count;
        case ({do_push, do_pop})
            2'b10:   count_next = count + 1'b1;
            2'b01:   count_next = count - 1'b1;
            default: count_next = count;    // Both or neither
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            wq_full  <= 1'b0;
            wq_empty <= 1'b1;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;   // Wraps since depth is a power of two
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count    <= count_next;
            wq_full  <= (count_next == (PTR_W+1)'(`WQ_DEPTH));
            wq_empty <= (count_next == '0);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            entries[wr_ptr] <= wq_entry;
        end
    end

    assign wq_head = entries[rd_ptr];

endmodule

/* src/line_store.sv */
`timescale 1ns/1ps
`include "mem_params.svh"

module line_store (
    input  logic                     clk,
    input  logic                     st_write,
    input  mem_addr_pkg::line_addr_t st_addr,
    input  mem_addr_pkg::offset_t    st_offset,
    input  mem_addr_pkg::word_t      st_wdata,
    input  logic                     st_read,
    output mem_addr_pkg::line_t      st_rdata
);

    localparam int LINE_W = `LINE_WORDS * `WORD_W;
    localparam int LINES  = `ADDR_W'(1) << (`ADDR_W - $clog2(`LINE_WORDS));

    logic [LINE_W-1:0] mem [LINES];

    // Memory starts out all zero
    initial begin
        for (int i = 0; i < LINES; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (st_write) begin
            mem[st_addr][st_offset*`WORD_W +: `WORD_W] <= st_wdata;   // Single word
        end
    end

    // Whole line one cycle after the read
    always_ff @(posedge clk) begin
        if (st_read) begin
            st_rdata <= mem[st_addr];
        end
    end

endmodule

/* src/cache_pkg.sv */
`include "mem_params.svh"

package cache_pkg;

    import mem_addr_pkg::*;

    localparam int INDEX_W = $clog2(`CACHE_LINES);
    localparam int TAG_W   = LINE_ADDR_W - INDEX_W;

    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [TAG_W-1:0]   tag_t;

    // One queued write-through of 44 bits
    typedef struct packed {
        word_addr_t addr;
        word_t      data;
    } write_entry_t;

    function automatic index_t index_of(line_addr_t line_addr);
        return line_addr[INDEX_W-1:0];
    endfunction

    function automatic tag_t tag_of(line_addr_t line_addr);
        return line_addr[LINE_ADDR_W-1:INDEX_W];
    endfunction

endpackage

/* src/mem_addr_pkg.sv */
`include "mem_params.svh"

package mem_addr_pkg;

    localparam int OFFSET_W    = $clog2(`LINE_WORDS);
    localparam int LINE_ADDR_W = `ADDR_W - OFFSET_W;

    typedef logic [`WORD_W-1:0]             word_t;
    typedef logic [`ADDR_W-1:0]             word_addr_t;
    typedef logic [`LINE_WORDS*`WORD_W-1:0] line_t;       // Word 0 in the low bits
    typedef logic [LINE_ADDR_W-1:0]         line_addr_t;
    typedef logic [OFFSET_W-1:0]            offset_t;

    // Line part of a word address
    function automatic line_addr_t line_of(word_addr_t addr);
        return addr[`ADDR_W-1:OFFSET_W];
    endfunction

    function automatic offset_t offset_of(word_addr_t addr);
        return addr[OFFSET_W-1:0];
    endfunction

    // Pick one word out of a line
    function automatic word_t word_of(line_t line, offset_t off);
        return line[off*`WORD_W +: `WORD_W];
    endfunction

endpackage

/* include/mem_params.svh */
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// Word address width for 4096 words in the store
`define ADDR_W 12

`define WORD_W 32

// Four words make a 128-bit line
`define LINE_WORDS 4

// Direct-mapped cache entries
`define CACHE_LINES 16

`define WQ_DEPTH 4

// Cycles from line read issue to fill ready
`define MEM_LATENCY 3

`endif
